//--- Makefile
VERILATOR ?= verilator
TOP       := cache_subsystem_tb
FILELIST  := sources.f
FLAGS     := --binary --timing --assert --timescale 1ns/1ps
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/cache_subsystem_chk.sv
`timescale 1ns/1ps

module cache_subsystem_chk (
	input logic                clk_i,
	input logic                reset_i,
	input logic                rsp_valid,
	input logic                rsp_ready,
	input cache_pkg::cpu_rsp_t rsp,
	input logic                mem_req_valid,
	input logic                mem_req_ready,
	input cache_pkg::mem_req_t mem_req
);

	// A response waiting for rsp_ready keeps its valid and its data.
	rsp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
			rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
		else $error("rsp changed or dropped before rsp_ready");

	mem_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
			mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
		else $error("mem_req changed or dropped before mem_req_ready");

	rsp_reset: assert property (@(posedge clk_i) reset_i |=> !rsp_valid)
		else $error("rsp_valid high in the cycle after reset");

endmodule

bind dcache cache_subsystem_chk u_chk (.*);

//--- sim/cache_subsystem_tb.sv
`timescale 1ns/1ps

module cache_subsystem_tb;

	localparam int CLK_PERIOD  = 8;
	localparam int MEM_LATENCY = 3;
	localparam int IDLE_CYCLES = 8;

	typedef struct packed {
		cache_pkg::addr_t        addr;
		logic                    write;
		cache_pkg::access_size_t size;
		cache_pkg::word_t        wr_data;
		cache_pkg::word_t        rd_data;
	} vector_t;

	logic                clk_i;
	logic                reset_i;
	logic                req_valid;
	logic                req_ready;
	cache_pkg::cpu_req_t req;
	logic                rsp_valid;
	logic                rsp_ready;
	cache_pkg::cpu_rsp_t rsp;

	string       names [$];
	vector_t     vectors [$];
	logic [31:0] lfsr;
	logic        saw_full;
	int          sent_count;
	int          recv_count;

	cache_subsystem #(
		.FIFO_DEPTH  (4),
		.NUM_LINES   (8),
		.LINE_WORDS  (4),
		.DEPTH_LINES (64),
		.MEM_LATENCY (MEM_LATENCY)
	) UUT (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req       (req),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp       (rsp)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	// Fibonacci LFSR with taps 32 22 2 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic add_vector(input string name, input cache_pkg::addr_t addr,
			input logic write, input cache_pkg::access_size_t size,
			input cache_pkg::word_t wr_data, input cache_pkg::word_t rd_data);
		vector_t v;
		v.addr    = addr;
		v.write   = write;
		v.size    = size;
		v.wr_data = wr_data;
		v.rd_data = rd_data;
		names.push_back(name);
		vectors.push_back(v);
	endtask

	// Index is addr[6:4], tag is addr[31:7]. Stores answer with zero data.
	task automatic build_table();
		add_vector("rd_zero", 32'h0000_0040, 1'b0, cache_pkg::WORD, 32'h0, 32'h0000_0000);
		add_vector("wr_word", 32'h0000_0080, 1'b1, cache_pkg::WORD, 32'hdead_beef, 32'h0);
		add_vector("rd_word", 32'h0000_0080, 1'b0, cache_pkg::WORD, 32'h0, 32'hdead_beef);
		add_vector("rd_neighbor", 32'h0000_0084, 1'b0, cache_pkg::WORD, 32'h0, 32'h0);
		add_vector("wr_byte0", 32'h0000_0090, 1'b1, cache_pkg::BYTE, 32'h0000_00a5, 32'h0);
		add_vector("wr_half2", 32'h0000_0092, 1'b1, cache_pkg::HALF, 32'h1234_c37e, 32'h0);
		add_vector("wr_byte3", 32'h0000_0093, 1'b1, cache_pkg::BYTE, 32'hffff_ff5a, 32'h0);
		add_vector("rd_merged", 32'h0000_0090, 1'b0, cache_pkg::WORD, 32'h0, 32'h5a7e_00a5);
		add_vector("rd_byte0", 32'h0000_0090, 1'b0, cache_pkg::BYTE, 32'h0, 32'h0000_00a5);
		add_vector("rd_byte1", 32'h0000_0091, 1'b0, cache_pkg::BYTE, 32'h0, 32'h0000_0000);
		add_vector("rd_byte3", 32'h0000_0093, 1'b0, cache_pkg::BYTE, 32'h0, 32'h0000_005a);
		add_vector("rd_half2", 32'h0000_0092, 1'b0, cache_pkg::HALF, 32'h0, 32'h0000_5a7e);
		add_vector("rd_half0", 32'h0000_0090, 1'b0, cache_pkg::HALF, 32'h0, 32'h0000_00a5);
		// Same index as 0x80 with another tag, so the dirty line goes back to memory.
		add_vector("wr_conflict", 32'h0000_0100, 1'b1, cache_pkg::WORD, 32'h1111_2222, 32'h0);
		add_vector("rd_evicted", 32'h0000_0080, 1'b0, cache_pkg::WORD, 32'h0, 32'hdead_beef);
		add_vector("rd_conflict", 32'h0000_0100, 1'b0, cache_pkg::WORD, 32'h0, 32'h1111_2222);
		add_vector("rd_evict_idx1", 32'h0000_0190, 1'b0, cache_pkg::WORD, 32'h0, 32'h0);
		add_vector("rd_refill_byte", 32'h0000_0093, 1'b0, cache_pkg::BYTE, 32'h0, 32'h5a);
		add_vector("wr_half_hi", 32'h0000_03fe, 1'b1, cache_pkg::HALF, 32'hbeef_cafe, 32'h0);
		add_vector("rd_half_hi", 32'h0000_03fe, 1'b0, cache_pkg::HALF, 32'h0, 32'h0000_cafe);
		add_vector("rd_word_hi", 32'h0000_03fc, 1'b0, cache_pkg::WORD, 32'h0, 32'hcafe_0000);
		add_vector("rd_byte_hi", 32'h0000_03ff, 1'b0, cache_pkg::BYTE, 32'h0, 32'h0000_00ca);
		add_vector("rd_zero_again", 32'h0000_0040, 1'b0, cache_pkg::WORD, 32'h0, 32'h0);
	endtask

	// Outputs are registered, so they are read at the falling edge.
	task automatic drive_requests();
		while (sent_count < vectors.size()) begin
			@(negedge clk_i);
			req_valid   = 1'b1;
			req.addr    = vectors[sent_count].addr;
			req.write   = vectors[sent_count].write;
			req.size    = vectors[sent_count].size;
			req.wr_data = vectors[sent_count].wr_data;
			if (req_ready)
				sent_count++;
			else
				saw_full = 1'b1;
		end
		@(negedge clk_i);
		req_valid = 1'b0;
		req       = '0;
	endtask

	task automatic collect_responses();
		cache_pkg::cpu_rsp_t exp_rsp;
		while (recv_count < vectors.size()) begin
			@(negedge clk_i);
			lfsr      = lfsr_next(lfsr);
			rsp_ready = lfsr[0];
			if (rsp_valid && rsp_ready) begin
				exp_rsp.rd_data = vectors[recv_count].rd_data;
				exp_rsp.write   = vectors[recv_count].write;
				assert (rsp == exp_rsp) else begin
					$display("Mismatch in %s: expected %h, actual %h",
							names[recv_count], exp_rsp, rsp);
					$display("SIMULATION FAILED");
					$fatal(1, "wrong response");
				end
				recv_count++;
			end
		end
	endtask

	task automatic check_no_extra();
		repeat (IDLE_CYCLES) begin
			@(negedge clk_i);
			rsp_ready = 1'b1;
			assert (!rsp_valid) else begin
				$display("Response seen after the last expected one");
				$display("SIMULATION FAILED");
				$fatal(1, "extra response");
			end
		end
	endtask

	task automatic watch_timeout();
		int limit;
		limit = vectors.size() * (2 * MEM_LATENCY + 6) * 4;
		repeat (limit) @(posedge clk_i);
		$display("Timeout: responses stopped after %0d of %0d", recv_count, vectors.size());
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired");
	endtask

	initial begin
		reset_i    = 1'b1;
		req_valid  = 1'b0;
		req        = '0;
		rsp_ready  = 1'b0;
		lfsr       = 32'he7be_3d3d;
		saw_full   = 1'b0;
		sent_count = 0;
		recv_count = 0;
		build_table();
		fork
			watch_timeout();
		join_none
		repeat (4) @(negedge clk_i);
		reset_i = 1'b0;
		fork
			drive_requests();
			collect_responses();
		join
		check_no_extra();
		assert (saw_full) else begin
			$display("Request queue never filled, req_ready stayed high");
			$display("SIMULATION FAILED");
			$fatal(1, "no back-pressure seen");
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- sources.f
verilog/cache_pkg.sv
verilog/cpu_req_fifo.sv
verilog/dcache.sv
verilog/line_memory.sv
verilog/cache_subsystem.sv
sim/cache_subsystem_chk.sv
sim/cache_subsystem_tb.sv

//--- verilog/cache_pkg.sv
package cache_pkg;

	localparam int ADDR_W = 32;
	localparam int WORD_W = 32;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [WORD_W-1:0] word_t;

	typedef enum logic [1:0] {
		BYTE,
		HALF,
		WORD
	} access_size_t;

	typedef struct packed {
		addr_t        addr;
		logic         write;
		access_size_t size;
		word_t        wr_data;
	} cpu_req_t;

	// The write bit echoes the kind of the request being answered.
	typedef struct packed {
		word_t rd_data;
		logic  write;
	} cpu_rsp_t;

	localparam int MAX_LINE_WORDS = 8;

	// Lines shorter than MAX_LINE_WORDS occupy the low words and leave the upper words zero.
	typedef logic [MAX_LINE_WORDS*WORD_W-1:0] line_data_t;

	typedef struct packed {
		addr_t      addr;
		logic       write;
		line_data_t wr_line;
	} mem_req_t;

endpackage

//--- verilog/cache_subsystem.sv
`timescale 1ns/1ps

module cache_subsystem #(
	parameter int FIFO_DEPTH  = 4,
	parameter int NUM_LINES   = 8,
	parameter int LINE_WORDS  = 4,
	parameter int DEPTH_LINES = 64,
	parameter int MEM_LATENCY = 3
) (
	input  logic                clk_i,
	input  logic                reset_i,
	input  logic                req_valid,
	output logic                req_ready,
	input  cache_pkg::cpu_req_t req,
	output logic                rsp_valid,
	input  logic                rsp_ready,
	output cache_pkg::cpu_rsp_t rsp
);

	logic                  q_valid;
	logic                  q_ready;
	cache_pkg::cpu_req_t   q_req;
	logic                  mem_req_valid;
	logic                  mem_req_ready;
	cache_pkg::mem_req_t   mem_req;
	logic                  mem_rsp_valid;
	cache_pkg::line_data_t mem_rsp_line;

	cpu_req_fifo #(
		.DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req       (req),
		.q_valid   (q_valid),
		.q_ready   (q_ready),
		.q_req     (q_req)
	);

	dcache #(
		.NUM_LINES  (NUM_LINES),
		.LINE_WORDS (LINE_WORDS)
	) u_dcache (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.q_valid       (q_valid),
		.q_ready       (q_ready),
		.q_req         (q_req),
		.rsp_valid     (rsp_valid),
		.rsp_ready     (rsp_ready),
		.rsp           (rsp),
		.mem_req_valid (mem_req_valid),
		.mem_req_ready (mem_req_ready),
		.mem_req       (mem_req),
		.mem_rsp_valid (mem_rsp_valid),
		.mem_rsp_line  (mem_rsp_line)
	);

	line_memory #(
		.DEPTH_LINES (DEPTH_LINES),
		.LINE_WORDS  (LINE_WORDS),
		.MEM_LATENCY (MEM_LATENCY)
	) u_memory (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.mem_req_valid (mem_req_valid),
		.mem_req_ready (mem_req_ready),
		.mem_req       (mem_req),
		.mem_rsp_valid (mem_rsp_valid),
		.mem_rsp_line  (mem_rsp_line)
	);

endmodule

//--- verilog/cpu_req_fifo.sv
`timescale 1ns/1ps

module cpu_req_fifo #(
	parameter int DEPTH = 4
) (
	input  logic                clk_i,
	input  logic                reset_i,
	input  logic                req_valid,
	output logic                req_ready,
	input  cache_pkg::cpu_req_t req,
	output logic                q_valid,
	input  logic                q_ready,
	output cache_pkg::cpu_req_t q_req
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [CNT_W-1:0] count_t;

	cache_pkg::cpu_req_t entries [DEPTH];
	ptr_t                wr_ptr;
	ptr_t                rd_ptr;
	count_t              count;
	logic                push;
	logic                pop;

	assign req_ready = count != count_t'(DEPTH);
	assign q_valid   = count != '0;
	assign q_req     = entries[rd_ptr];

	assign push = req_valid && req_ready;
	assign pop  = q_valid && q_ready;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	// Entry storage.
	always_ff @(posedge clk_i) begin
		if (push) begin
			entries[wr_ptr] <= req;
		end
	end

endmodule

//--- verilog/dcache.sv
`timescale 1ns/1ps

module dcache #(
	parameter int NUM_LINES  = 8,
	parameter int LINE_WORDS = 4
) (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic                  q_valid,
	output logic                  q_ready,
	input  cache_pkg::cpu_req_t   q_req,
	output logic                  rsp_valid,
	input  logic                  rsp_ready,
	output cache_pkg::cpu_rsp_t   rsp,
	output logic                  mem_req_valid,
	input  logic                  mem_req_ready,
	output cache_pkg::mem_req_t   mem_req,
	input  logic                  mem_rsp_valid,
	input  cache_pkg::line_data_t mem_rsp_line
);

	localparam int BYTE_OFF_W = $clog2(cache_pkg::WORD_W / 8);
	localparam int WORD_SEL_W = $clog2(LINE_WORDS);
	localparam int INDEX_W    = $clog2(NUM_LINES);
	localparam int TAG_W      = cache_pkg::ADDR_W - INDEX_W - WORD_SEL_W - BYTE_OFF_W;
	localparam int LINE_BITS  = LINE_WORDS * cache_pkg::WORD_W;

	typedef logic [TAG_W-1:0]      tag_t;
	typedef logic [INDEX_W-1:0]    index_t;
	typedef logic [WORD_SEL_W-1:0] word_sel_t;
	typedef logic [BYTE_OFF_W-1:0] byte_off_t;
	typedef logic [LINE_WORDS-1:0][cache_pkg::WORD_W-1:0] line_t;

	typedef struct packed {
		tag_t      tag;
		index_t    index;
		word_sel_t word;
		byte_off_t boff;
	} split_addr_t;

	typedef enum logic [2:0] {
		READY,
		WRITEBACK_REQ,
		WRITEBACK_WAIT,
		FILL_REQ,
		FILL_WAIT
	} state_t;

	function automatic cache_pkg::word_t merge_store(input cache_pkg::word_t old_word,
			input cache_pkg::word_t wdata, input cache_pkg::access_size_t size,
			input byte_off_t boff);
		cache_pkg::word_t result;
		result = old_word;
		case (size)
		cache_pkg::BYTE: result[8*boff +: 8] = wdata[7:0];
		cache_pkg::HALF: result[8*boff +: 16] = wdata[15:0];
		default: result = wdata;
		endcase
		return result;
	endfunction

	// Zero-extends the addressed byte or half.
	function automatic cache_pkg::word_t load_extract(input cache_pkg::word_t word,
			input cache_pkg::access_size_t size, input byte_off_t boff);
		cache_pkg::word_t result;
		result = '0;
		case (size)
		cache_pkg::BYTE: result[7:0] = word[8*boff +: 8];
		cache_pkg::HALF: result[15:0] = word[8*boff +: 16];
		default: result = word;
		endcase
		return result;
	endfunction

	state_t             state;
	state_t             next_state;
	tag_t               tags [NUM_LINES];
	line_t              lines [NUM_LINES];
	logic [NUM_LINES-1:0] line_valid;
	logic [NUM_LINES-1:0] line_dirty;
	split_addr_t        req_addr;
	line_t              cur_line;
	line_t              fill_line;
	cache_pkg::word_t   store_word;
	logic               hit;
	logic               rsp_free;
	logic               complete;
	logic               fill_done;

	assign req_addr   = q_req.addr;
	assign cur_line   = lines[req_addr.index];
	assign hit        = line_valid[req_addr.index] && (tags[req_addr.index] == req_addr.tag);
	assign rsp_free   = !rsp_valid || rsp_ready;
	assign complete   = (state == READY) && q_valid && hit && rsp_free;
	assign q_ready    = complete;
	assign fill_done  = (state == FILL_WAIT) && mem_rsp_valid;
	assign store_word = merge_store(cur_line[req_addr.word], q_req.wr_data, q_req.size,
			req_addr.boff);

	// Incoming line with store data already merged in.
	always_comb begin
		fill_line = mem_rsp_line[LINE_BITS-1:0];
		if (q_req.write) begin
			fill_line[req_addr.word] = merge_store(fill_line[req_addr.word], q_req.wr_data,
					q_req.size, req_addr.boff);
		end
	end

	always_comb begin
		next_state = state;
		case (state)
		READY: begin
			if (q_valid && !hit) begin
				if (line_valid[req_addr.index] && line_dirty[req_addr.index])
					next_state = WRITEBACK_REQ;
				else
					next_state = FILL_REQ;
			end
		end
		WRITEBACK_REQ: begin
			if (mem_req_ready)
				next_state = WRITEBACK_WAIT;
		end
		WRITEBACK_WAIT: begin
			if (mem_rsp_valid)
				next_state = FILL_REQ;
		end
		FILL_REQ: begin
			if (mem_req_ready)
				next_state = FILL_WAIT;
		end
		FILL_WAIT: begin
			if (mem_rsp_valid)
				next_state = READY;
		end
		default: next_state = READY;
		endcase
	end

	always_comb begin
		mem_req_valid = 1'b0;
		mem_req       = '0;
		case (state)
		WRITEBACK_REQ: begin
			mem_req_valid = 1'b1;
			mem_req.addr  = {tags[req_addr.index], req_addr.index,
					{(WORD_SEL_W + BYTE_OFF_W){1'b0}}};
			mem_req.write = 1'b1;
			mem_req.wr_line[LINE_BITS-1:0] = cur_line;
		end
		FILL_REQ: begin
			mem_req_valid = 1'b1;
			mem_req.addr  = {req_addr.tag, req_addr.index,
					{(WORD_SEL_W + BYTE_OFF_W){1'b0}}};
		end
		default: ;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state      <= READY;
			line_valid <= '0;
			line_dirty <= '0;
			rsp_valid  <= 1'b0;
		end else begin
			state <= next_state;
			if (complete)
				rsp_valid <= 1'b1;
			else if (rsp_ready)
				rsp_valid <= 1'b0;
			if (complete && q_req.write)
				line_dirty[req_addr.index] <= 1'b1;
			if (state == WRITEBACK_WAIT && mem_rsp_valid)
				line_dirty[req_addr.index] <= 1'b0;
			if (fill_done) begin
				line_valid[req_addr.index] <= 1'b1;
				line_dirty[req_addr.index] <= q_req.write;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (fill_done) begin
			lines[req_addr.index] <= fill_line;
			tags[req_addr.index]  <= req_addr.tag;
		end else if (complete && q_req.write) begin
			lines[req_addr.index][req_addr.word] <= store_word;
		end
		if (complete) begin
			rsp.write   <= q_req.write;
			rsp.rd_data <= q_req.write ? '0 :
					load_extract(cur_line[req_addr.word], q_req.size, req_addr.boff);
		end
	end

endmodule

//--- verilog/line_memory.sv
`timescale 1ns/1ps

module line_memory #(
	parameter int DEPTH_LINES = 64,
	parameter int LINE_WORDS  = 4,
	parameter int MEM_LATENCY = 3
) (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic                  mem_req_valid,
	output logic                  mem_req_ready,
	input  cache_pkg::mem_req_t   mem_req,
	output logic                  mem_rsp_valid,
	output cache_pkg::line_data_t mem_rsp_line
);

	localparam int LINE_BITS  = LINE_WORDS * cache_pkg::WORD_W;
	localparam int LINE_OFF_W = $clog2(LINE_BITS / 8);
	localparam int LIDX_W     = $clog2(DEPTH_LINES);
	localparam int CNT_W      = $clog2(MEM_LATENCY + 1);

	typedef logic [LIDX_W-1:0]    line_idx_t;
	typedef logic [LINE_BITS-1:0] line_t;

	line_t            mem [DEPTH_LINES];
	logic [CNT_W-1:0] count;
	line_idx_t        pend_idx;
	logic             pend_write;
	line_t            pend_line;
	logic             accept;

	// Idle only when no transaction is counting down.
	assign mem_req_ready = count == '0;
	assign accept        = mem_req_valid && mem_req_ready;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			count         <= '0;
			mem_rsp_valid <= 1'b0;
			for (int i = 0; i < DEPTH_LINES; i++)
				mem[i] <= '0;
		end else begin
			mem_rsp_valid <= 1'b0;
			if (accept) begin
				count <= CNT_W'(MEM_LATENCY);
			end else if (count != '0) begin
				count <= count - 1'b1;
				if (count == CNT_W'(1)) begin
					mem_rsp_valid <= 1'b1;
					if (pend_write)
						mem[pend_idx] <= pend_line;
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			pend_idx   <= mem_req.addr[LINE_OFF_W +: LIDX_W];
			pend_write <= mem_req.write;
			pend_line  <= mem_req.wr_line[LINE_BITS-1:0];
		end
		if (count == CNT_W'(1))
			mem_rsp_line <= cache_pkg::line_data_t'(mem[pend_idx]);
	end

endmodule
